// File: hdl/axil_pkg.sv
/* AXI-Lite bus definitions */

package axil_pkg;

    localparam int data_width = 32;  // one register word
    localparam int strb_width = 4;   // byte lanes per word

    // every access is answered OKAY
    typedef enum logic [1:0] {
        resp_okay = 2'b00
    } axil_resp_e;

endpackage

// File: hdl/csr_pkg.sv
/* Voxel CSR register map */

package csr_pkg;

    // ========================================
    // word offsets (byte offset / 4)
    // ========================================
    typedef enum logic [7:0] {
        w_id          = 8'h00,
        w_rev         = 8'h01,
        w_ctrl        = 8'h04,
        w_status      = 8'h05,
        w_cam_x       = 8'h08,
        w_cam_y       = 8'h09,
        w_cam_z       = 8'h0a,
        w_cam_dir_x   = 8'h0b,
        w_cam_dir_y   = 8'h0c,
        w_cam_dir_z   = 8'h0d,
        w_cam_plane_x = 8'h0e,
        w_cam_plane_y = 8'h0f,
        w_flags       = 8'h10,
        w_sel_active  = 8'h11,
        w_sel_x       = 8'h12,
        w_sel_y       = 8'h13,
        w_sel_z       = 8'h14,
        w_int_status  = 8'h20,
        w_int_mask    = 8'h21,
        w_irq_test    = 8'h22
    } csr_word_e;

    typedef logic signed [15:0] cam_t;
    typedef logic [5:0]         sel_coord_t;

    typedef struct packed {
        logic diag_slice;   // bit 3
        logic extra_light;
        logic curvature;
        logic smooth;       // bit 0
    } render_flags_t;

    localparam render_flags_t flags_reset = '{
        diag_slice: 1'b0, extra_light: 1'b0, curvature: 1'b1, smooth: 1'b1
    };

    localparam int ctrl_soft_reset_bit  = 0;
    localparam int ctrl_start_frame_bit = 1;

    localparam int irq_frame_done_bit = 0;
    localparam int irq_test_bit       = 3;

endpackage

// File: hdl/csr_bus_if.sv
/* Internal register access bus */

interface csr_bus_if;

    logic                                wr_en;    // one-cycle strobe
    csr_pkg::csr_word_e                  wr_word;
    logic [axil_pkg::data_width-1:0]     wdata;
    logic [axil_pkg::strb_width-1:0]     wstrb;
    logic                                rd_en;    // one-cycle strobe
    csr_pkg::csr_word_e                  rd_word;

    modport port (
        output wr_en, wr_word, wdata, wstrb,
        output rd_en, rd_word
    );

    modport bank (
        input wr_en, wr_word, wdata, wstrb,
        input rd_en, rd_word
    );

endinterface

// File: hdl/axil_slave_port.sv
/* AXI-Lite slave port */

module axil_slave_port #(
    parameter int addr_width = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [addr_width-1:0]           awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [axil_pkg::data_width-1:0] wdata,
    input  logic [axil_pkg::strb_width-1:0] wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output axil_pkg::axil_resp_e            bresp,
    output logic                            bvalid,
    input  logic                            bready,

    input  logic [addr_width-1:0]           araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [axil_pkg::data_width-1:0] rdata,
    output axil_pkg::axil_resp_e            rresp,
    output logic                            rvalid,
    input  logic                            rready,

    csr_bus_if.port                         bus,
    input  logic [axil_pkg::data_width-1:0] ctrl_rdata,
    input  logic [axil_pkg::data_width-1:0] irq_rdata
);

    logic wr_accept;
    logic rd_accept;

    assign wr_accept = awready && awvalid && wready && wvalid && !bvalid;
    assign rd_accept = arready && arvalid && !rvalid;

    assign bresp = axil_pkg::resp_okay;
    assign rresp = axil_pkg::resp_okay;

    // word offset from addr[9:2]
    assign bus.wr_en   = wr_accept;
    assign bus.wr_word = csr_pkg::csr_word_e'(awaddr[9:2]);
    assign bus.wdata   = wdata;
    assign bus.wstrb   = wstrb;
    assign bus.rd_en   = rd_accept;
    assign bus.rd_word = csr_pkg::csr_word_e'(araddr[9:2]);

    // ========================================
    // write channel
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (!awready) awready <= awvalid;  // re-arm
            if (!wready)  wready  <= wvalid;
            if (wr_accept) begin
                bvalid  <= 1'b1;
                awready <= 1'b0;
                wready  <= 1'b0;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;  // held until consumed
            end
        end
    end

    // ========================================
    // read channel
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (!arready) arready <= arvalid;
            if (rd_accept) begin
                rvalid  <= 1'b1;
                arready <= 1'b0;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) rdata <= ctrl_rdata | irq_rdata;  // banks return zero off-map
    end

endmodule

// File: hdl/render_ctrl_regs.sv
/* Render control registers */

module render_ctrl_regs (
    input  logic                             clk,
    input  logic                             rst_n,
    csr_bus_if.bank                          bus,
    output logic [axil_pkg::data_width-1:0]  ctrl_rdata,
    output csr_pkg::cam_t                    cam_x, cam_y, cam_z,
    output csr_pkg::cam_t                    cam_dir_x, cam_dir_y, cam_dir_z,
    output csr_pkg::cam_t                    cam_plane_x, cam_plane_y,
    output logic                             cam_load_pulse,
    output logic                             flags_load_pulse,
    output logic                             sel_load_pulse,
    output logic                             sel_active,
    output csr_pkg::render_flags_t           flags,
    output csr_pkg::sel_coord_t              sel_x, sel_y, sel_z,
    output logic                             soft_reset_pulse,
    output logic                             start_frame_pulse
);

    csr_pkg::cam_t                   cam_q [0:7];
    logic [axil_pkg::data_width-1:0] ctrl_shadow;
    logic [7:0]                      wr_off;
    logic [7:0]                      rd_off;

    function automatic logic [axil_pkg::data_width-1:0] merge_wstrb(
        input logic [axil_pkg::data_width-1:0] cur,
        input logic [axil_pkg::data_width-1:0] din,
        input logic [axil_pkg::strb_width-1:0] strb
    );
        logic [axil_pkg::data_width-1:0] res;
        res = cur;
        for (int i = 0; i < axil_pkg::strb_width; i++) begin
            if (strb[i]) res[8*i +: 8] = din[8*i +: 8];
        end
        return res;
    endfunction

    assign wr_off = bus.wr_word;
    assign rd_off = bus.rd_word;

    assign cam_x       = cam_q[0];
    assign cam_y       = cam_q[1];
    assign cam_z       = cam_q[2];
    assign cam_dir_x   = cam_q[3];
    assign cam_dir_y   = cam_q[4];
    assign cam_dir_z   = cam_q[5];
    assign cam_plane_x = cam_q[6];
    assign cam_plane_y = cam_q[7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) cam_q[i] <= '0;
            ctrl_shadow       <= '0;
            flags             <= csr_pkg::flags_reset;
            sel_active        <= 1'b0;
            sel_x             <= '0;
            sel_y             <= '0;
            sel_z             <= '0;
            cam_load_pulse    <= 1'b0;
            flags_load_pulse  <= 1'b0;
            sel_load_pulse    <= 1'b0;
            soft_reset_pulse  <= 1'b0;
            start_frame_pulse <= 1'b0;
        end else begin
            cam_load_pulse    <= 1'b0;
            flags_load_pulse  <= 1'b0;
            sel_load_pulse    <= 1'b0;
            soft_reset_pulse  <= 1'b0;
            start_frame_pulse <= 1'b0;
            if (soft_reset_pulse) begin  // deferred soft reset
                flags            <= csr_pkg::flags_reset;
                ctrl_shadow[3:2] <= 2'b00;
            end
            if (bus.wr_en) begin
                case (bus.wr_word)
                    csr_pkg::w_ctrl: begin
                        ctrl_shadow <= merge_wstrb(ctrl_shadow, bus.wdata, bus.wstrb);
                        if (bus.wdata[csr_pkg::ctrl_soft_reset_bit])  soft_reset_pulse  <= 1'b1;
                        if (bus.wdata[csr_pkg::ctrl_start_frame_bit]) start_frame_pulse <= 1'b1;
                        if (|bus.wdata[3:2]) begin  // flag shortcut
                            flags.diag_slice  <= bus.wdata[2];
                            flags.extra_light <= bus.wdata[3];
                            flags_load_pulse  <= 1'b1;
                            ctrl_shadow[3:2]  <= bus.wdata[3:2];
                        end
                    end
                    csr_pkg::w_cam_x, csr_pkg::w_cam_y, csr_pkg::w_cam_z,
                    csr_pkg::w_cam_dir_x, csr_pkg::w_cam_dir_y, csr_pkg::w_cam_dir_z,
                    csr_pkg::w_cam_plane_x, csr_pkg::w_cam_plane_y: begin
                        cam_q[wr_off[2:0]] <= bus.wdata[15:0];
                        cam_load_pulse     <= 1'b1;
                    end
                    csr_pkg::w_flags: begin
                        flags            <= csr_pkg::render_flags_t'(bus.wdata[3:0]);
                        flags_load_pulse <= 1'b1;
                    end
                    csr_pkg::w_sel_active: begin
                        sel_active     <= bus.wdata[0];
                        sel_load_pulse <= 1'b1;
                    end
                    csr_pkg::w_sel_x: begin
                        sel_x          <= bus.wdata[5:0];
                        sel_load_pulse <= 1'b1;
                    end
                    csr_pkg::w_sel_y: begin
                        sel_y          <= bus.wdata[5:0];
                        sel_load_pulse <= 1'b1;
                    end
                    csr_pkg::w_sel_z: begin
                        sel_z          <= bus.wdata[5:0];
                        sel_load_pulse <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // ========================================
    // read mux
    // ========================================
    always_comb begin
        ctrl_rdata = '0;
        case (bus.rd_word)
            csr_pkg::w_ctrl: ctrl_rdata = {ctrl_shadow[31:6], 2'b00, ctrl_shadow[3:2], 2'b00};
            csr_pkg::w_cam_x, csr_pkg::w_cam_y, csr_pkg::w_cam_z,
            csr_pkg::w_cam_dir_x, csr_pkg::w_cam_dir_y, csr_pkg::w_cam_dir_z,
            csr_pkg::w_cam_plane_x, csr_pkg::w_cam_plane_y:
                ctrl_rdata = {{16{cam_q[rd_off[2:0]][15]}}, cam_q[rd_off[2:0]]};  // sign-extend
            csr_pkg::w_flags:      ctrl_rdata = {28'd0, flags};
            csr_pkg::w_sel_active: ctrl_rdata = {31'd0, sel_active};
            csr_pkg::w_sel_x:      ctrl_rdata = {26'd0, sel_x};
            csr_pkg::w_sel_y:      ctrl_rdata = {26'd0, sel_y};
            csr_pkg::w_sel_z:      ctrl_rdata = {26'd0, sel_z};
            default: ;
        endcase
    end

endmodule

// File: hdl/irq_status_regs.sv
/* Identity, status and interrupts */

module irq_status_regs #(
    parameter logic [15:0] vendor_id = 16'h1bad,
    parameter logic [15:0] device_id = 16'h2024,
    parameter logic [7:0]  rev_id    = 8'h01,
    parameter logic [7:0]  build_id  = 8'h00
) (
    input  logic                            clk,
    input  logic                            rst_n,
    csr_bus_if.bank                         bus,
    output logic [axil_pkg::data_width-1:0] irq_rdata,
    input  logic                            frame_done_pulse,
    input  logic                            core_busy,
    input  logic                            soft_reset_pulse,
    input  logic                            start_frame_pulse,
    output logic                            irq
);

    logic                            frame_done_q;  // clear-on-read latch
    logic [axil_pkg::data_width-1:0] int_status;
    logic [axil_pkg::data_width-1:0] int_mask;
    logic                            status_read;

    assign status_read = bus.rd_en && (bus.rd_word == csr_pkg::w_status);
    assign irq         = |(int_status & int_mask);  // level

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done_q <= 1'b0;
            int_status   <= '0;
            int_mask     <= '0;
        end else begin
            if (status_read) frame_done_q <= 1'b0;
            if (soft_reset_pulse) begin
                frame_done_q <= 1'b0;
                int_status   <= '0;
            end
            if (start_frame_pulse) begin
                frame_done_q                         <= 1'b0;
                int_status[csr_pkg::irq_frame_done_bit] <= 1'b0;
            end
            if (frame_done_pulse) begin
                frame_done_q                         <= 1'b1;
                int_status[csr_pkg::irq_frame_done_bit] <= 1'b1;
            end
            if (bus.wr_en) begin
                case (bus.wr_word)
                    csr_pkg::w_int_status: int_status <= int_status & ~bus.wdata;  // w1c
                    csr_pkg::w_int_mask:   int_mask   <= bus.wdata;
                    csr_pkg::w_irq_test:
                        if (bus.wdata[0]) int_status[csr_pkg::irq_test_bit] <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        irq_rdata = '0;
        case (bus.rd_word)
            csr_pkg::w_id:         irq_rdata = {vendor_id, device_id};
            csr_pkg::w_rev:        irq_rdata = {16'd0, build_id, rev_id};
            csr_pkg::w_status:     irq_rdata = {30'd0, frame_done_q, core_busy};
            csr_pkg::w_int_status: irq_rdata = int_status;
            csr_pkg::w_int_mask:   irq_rdata = int_mask;
            default: ;
        endcase
    end

endmodule

// File: hdl/voxel_csr_top.sv
/* Voxel CSR block top */

module voxel_csr_top #(
    parameter int          addr_width = 16,
    parameter logic [15:0] vendor_id  = 16'h1bad,
    parameter logic [15:0] device_id  = 16'h2024,
    parameter logic [7:0]  rev_id     = 8'h01,
    parameter logic [7:0]  build_id   = 8'h00
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // AXI-Lite slave
    input  logic [addr_width-1:0]           s_axil_awaddr,
    input  logic                            s_axil_awvalid,
    output logic                            s_axil_awready,
    input  logic [axil_pkg::data_width-1:0] s_axil_wdata,
    input  logic [axil_pkg::strb_width-1:0] s_axil_wstrb,
    input  logic                            s_axil_wvalid,
    output logic                            s_axil_wready,
    output axil_pkg::axil_resp_e            s_axil_bresp,
    output logic                            s_axil_bvalid,
    input  logic                            s_axil_bready,
    input  logic [addr_width-1:0]           s_axil_araddr,
    input  logic                            s_axil_arvalid,
    output logic                            s_axil_arready,
    output logic [axil_pkg::data_width-1:0] s_axil_rdata,
    output axil_pkg::axil_resp_e            s_axil_rresp,
    output logic                            s_axil_rvalid,
    input  logic                            s_axil_rready,

    // render core side
    output csr_pkg::cam_t                   cam_x, cam_y, cam_z,
    output csr_pkg::cam_t                   cam_dir_x, cam_dir_y, cam_dir_z,
    output csr_pkg::cam_t                   cam_plane_x, cam_plane_y,
    output logic                            cam_load_pulse,
    output logic                            flags_load_pulse,
    output logic                            sel_load_pulse,
    output logic                            sel_active,
    output csr_pkg::render_flags_t          flags,
    output csr_pkg::sel_coord_t             sel_x, sel_y, sel_z,
    output logic                            soft_reset_pulse,
    output logic                            start_frame_pulse,
    input  logic                            frame_done_pulse,
    input  logic                            core_busy,
    output logic                            irq_out
);

    logic [axil_pkg::data_width-1:0] ctrl_rdata;
    logic [axil_pkg::data_width-1:0] irq_rdata;

    csr_bus_if csr_bus ();

    axil_slave_port #(.addr_width(addr_width)) u_port (
        .clk, .rst_n,
        .awaddr(s_axil_awaddr), .awvalid(s_axil_awvalid), .awready(s_axil_awready),
        .wdata(s_axil_wdata), .wstrb(s_axil_wstrb), .wvalid(s_axil_wvalid),
        .wready(s_axil_wready), .bresp(s_axil_bresp), .bvalid(s_axil_bvalid),
        .bready(s_axil_bready), .araddr(s_axil_araddr), .arvalid(s_axil_arvalid),
        .arready(s_axil_arready), .rdata(s_axil_rdata), .rresp(s_axil_rresp),
        .rvalid(s_axil_rvalid), .rready(s_axil_rready),
        .bus(csr_bus.port), .ctrl_rdata, .irq_rdata
    );

    render_ctrl_regs u_render (
        .clk, .rst_n, .bus(csr_bus.bank), .ctrl_rdata,
        .cam_x, .cam_y, .cam_z, .cam_dir_x, .cam_dir_y, .cam_dir_z,
        .cam_plane_x, .cam_plane_y, .cam_load_pulse, .flags_load_pulse,
        .sel_load_pulse, .sel_active, .flags, .sel_x, .sel_y, .sel_z,
        .soft_reset_pulse, .start_frame_pulse
    );

    irq_status_regs #(
        .vendor_id(vendor_id), .device_id(device_id),
        .rev_id(rev_id), .build_id(build_id)
    ) u_irq (
        .clk, .rst_n, .bus(csr_bus.bank), .irq_rdata,
        .frame_done_pulse, .core_busy, .soft_reset_pulse, .start_frame_pulse,
        .irq(irq_out)
    );

endmodule

// File: verif/clk_gen.sv
/* Testbench clock and reset */

module clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: verif/voxel_csr_tb.sv
/* Voxel CSR block testbench */

module voxel_csr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          addr_width      = 16;
    localparam logic [15:0] vendor_id       = 16'hc5a1;
    localparam logic [15:0] device_id       = 16'h7e02;
    localparam logic [7:0]  rev_id          = 8'h03;
    localparam logic [7:0]  build_id        = 8'h2b;
    localparam int          num_tests       = 6;
    localparam int          cycles_per_test = 200;
    localparam int          resp_limit      = 16;  // cycles to wait for a handshake

    logic                   clk;
    logic                   rst_n;
    logic [addr_width-1:0]  s_axil_awaddr;
    logic                   s_axil_awvalid;
    logic                   s_axil_awready;
    logic [31:0]            s_axil_wdata;
    logic [3:0]             s_axil_wstrb;
    logic                   s_axil_wvalid;
    logic                   s_axil_wready;
    axil_pkg::axil_resp_e   s_axil_bresp;
    logic                   s_axil_bvalid;
    logic                   s_axil_bready;
    logic [addr_width-1:0]  s_axil_araddr;
    logic                   s_axil_arvalid;
    logic                   s_axil_arready;
    logic [31:0]            s_axil_rdata;
    axil_pkg::axil_resp_e   s_axil_rresp;
    logic                   s_axil_rvalid;
    logic                   s_axil_rready;
    csr_pkg::cam_t          cam_x, cam_y, cam_z, cam_dir_x, cam_dir_y, cam_dir_z;
    csr_pkg::cam_t          cam_plane_x, cam_plane_y;
    logic                   cam_load_pulse, flags_load_pulse, sel_load_pulse, sel_active;
    csr_pkg::render_flags_t flags;
    csr_pkg::sel_coord_t    sel_x, sel_y, sel_z;
    logic                   soft_reset_pulse, start_frame_pulse;
    logic                   frame_done_pulse, core_busy, irq_out;

    int         mismatches;
    int         failures;
    integer     seed;
    logic [4:0] pulse_on;     // cam, flags, sel, soft reset, start frame
    logic [4:0] pulse_after;  // same pulses one cycle later

    clk_gen u_clk (.clk, .rst_n);

    voxel_csr_top #(
        .addr_width(addr_width), .vendor_id(vendor_id), .device_id(device_id),
        .rev_id(rev_id), .build_id(build_id)
    ) u_dut (.*);

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_cam(input string name, input csr_pkg::cam_t got,
                             input csr_pkg::cam_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flags(input string name, input csr_pkg::render_flags_t got,
                               input csr_pkg::render_flags_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            mismatches++;
        end
    endtask

    function automatic logic [addr_width-1:0] addr_of(input csr_pkg::csr_word_e word);
        return addr_width'({word, 2'b00});  // byte address
    endfunction

    function automatic logic [4:0] current_pulses();
        return {cam_load_pulse, flags_load_pulse, sel_load_pulse,
                soft_reset_pulse, start_frame_pulse};
    endfunction

    function automatic csr_pkg::cam_t cam_port(input int idx);
        csr_pkg::cam_t ports [0:7];
        ports = '{cam_x, cam_y, cam_z, cam_dir_x, cam_dir_y, cam_dir_z,
                  cam_plane_x, cam_plane_y};
        return ports[idx];
    endfunction

    function automatic csr_pkg::sel_coord_t sel_port(input int idx);
        return (idx == 0) ? sel_x : (idx == 1) ? sel_y : sel_z;
    endfunction

    // high in the cycle after the write, low the cycle after that
    task automatic expect_pulse(input string name, input int idx);
        check_bit(name, pulse_on[idx], 1'b1);
        check_bit({name, " next cycle"}, pulse_after[idx], 1'b0);
    endtask

    // ========================================
    // AXI-Lite driver
    // ========================================
    task automatic axil_write(input csr_pkg::csr_word_e word, input logic [31:0] data);
        int waited;
        waited         = 0;
        s_axil_awaddr  = addr_of(word);
        s_axil_wdata   = data;
        s_axil_wstrb   = 4'hf;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = 1'b1;
        @(posedge clk);
        #1;
        while (!s_axil_bvalid && waited < resp_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        if (!s_axil_bvalid) begin
            $display("ERROR: no write response for word 0x%h", word);
            failures++;
        end else begin
            check_word("bresp", 32'(s_axil_bresp), 32'h0);
            pulse_on = current_pulses();
            @(posedge clk);
            #1;
            pulse_after = current_pulses();
        end
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input csr_pkg::csr_word_e word, output logic [31:0] data);
        int waited;
        waited         = 0;
        data           = '0;
        s_axil_araddr  = addr_of(word);
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        @(posedge clk);
        #1;
        while (!s_axil_rvalid && waited < resp_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        s_axil_arvalid = 1'b0;
        if (!s_axil_rvalid) begin
            $display("ERROR: no read data for word 0x%h", word);
            failures++;
        end else begin
            check_word("rresp", 32'(s_axil_rresp), 32'h0);
            data = s_axil_rdata;
            @(posedge clk);
            #1;
        end
        s_axil_rready = 1'b0;
    endtask

    task automatic pulse_frame_done();
        frame_done_pulse = 1'b1;
        @(posedge clk);
        #1;
        frame_done_pulse = 1'b0;
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic reset_and_id();
        logic [31:0] rd;
        check_bit("irq_out", irq_out, 1'b0);
        check_bit("bvalid", s_axil_bvalid, 1'b0);
        check_bit("rvalid", s_axil_rvalid, 1'b0);
        check_bit("awready", s_axil_awready, 1'b0);
        check_bit("wready", s_axil_wready, 1'b0);
        check_bit("arready", s_axil_arready, 1'b0);
        check_flags("flags", flags, csr_pkg::flags_reset);
        axil_read(csr_pkg::w_id, rd);
        check_word("id", rd, {vendor_id, device_id});
        axil_read(csr_pkg::w_rev, rd);
        check_word("rev", rd, {16'h0000, build_id, rev_id});
    endtask

    task automatic camera_regs();
        logic [31:0] val;
        logic [31:0] rd;
        logic [7:0]  off;
        for (int i = 0; i < 8; i++) begin
            val = $random(seed);
            off = 8'h08 + 8'(i);  // camera words start at 0x08
            axil_write(csr_pkg::csr_word_e'(off), val);
            expect_pulse("cam_load_pulse", 4);
            check_cam($sformatf("cam port %0d", i), cam_port(i), csr_pkg::cam_t'(val[15:0]));
            axil_read(csr_pkg::csr_word_e'(off), rd);
            check_word($sformatf("cam readback %0d", i), rd, {{16{val[15]}}, val[15:0]});
        end
    endtask

    task automatic flag_regs();
        logic [31:0] rd;
        axil_write(csr_pkg::w_flags, 32'h0000_000f);
        expect_pulse("flags_load_pulse", 3);
        check_flags("flags", flags, 4'b1111);
        axil_read(csr_pkg::w_flags, rd);
        check_word("flags readback", rd, 32'h0000_000f);
        axil_write(csr_pkg::w_flags, 32'h0000_0006);  // curvature and extra_light
        check_flags("flags", flags, 4'b0110);
        // shortcut bit 2 is diag_slice, bits 4 and 5 are ignored
        axil_write(csr_pkg::w_ctrl, 32'h0000_0034);
        expect_pulse("flags_load_pulse", 3);
        check_flags("flags after ctrl", flags, 4'b1010);
        axil_read(csr_pkg::w_ctrl, rd);
        check_word("ctrl readback", rd, 32'h0000_0004);
    endtask

    task automatic selection_regs();
        logic [31:0] val;
        logic [31:0] rd;
        axil_write(csr_pkg::w_sel_active, 32'h0000_0001);
        expect_pulse("sel_load_pulse", 2);
        check_bit("sel_active", sel_active, 1'b1);
        for (int i = 0; i < 3; i++) begin
            val = $random(seed);
            axil_write(csr_pkg::csr_word_e'(8'h12 + 8'(i)), val);
            expect_pulse("sel_load_pulse", 2);
            check_word($sformatf("sel port %0d", i), 32'(sel_port(i)), val & 32'h3f);
            axil_read(csr_pkg::csr_word_e'(8'h12 + 8'(i)), rd);
            check_word($sformatf("sel readback %0d", i), rd, val & 32'h3f);
        end
    endtask

    task automatic frame_done_irq();
        logic [31:0] rd;
        core_busy = 1'b1;
        pulse_frame_done();
        axil_read(csr_pkg::w_status, rd);
        check_word("status", rd, 32'h0000_0003);
        axil_read(csr_pkg::w_status, rd);
        check_word("status second read", rd, 32'h0000_0001);  // latch cleared by read
        core_busy = 1'b0;
        axil_read(csr_pkg::w_int_status, rd);
        check_word("int_status", rd, 32'h0000_0001);
        check_bit("irq_out masked", irq_out, 1'b0);
        axil_write(csr_pkg::w_int_mask, 32'h0000_0001);
        check_bit("irq_out enabled", irq_out, 1'b1);
        axil_write(csr_pkg::w_irq_test, 32'h0000_0001);
        axil_read(csr_pkg::w_int_status, rd);
        check_word("int_status irq test", rd, 32'h0000_0009);
        axil_write(csr_pkg::w_int_status, 32'h0000_0001);  // w1c
        axil_read(csr_pkg::w_int_status, rd);
        check_word("int_status after w1c", rd, 32'h0000_0008);
        check_bit("irq_out after w1c", irq_out, 1'b0);
        axil_write(csr_pkg::w_int_status, 32'h0000_0008);
    endtask

    task automatic soft_reset_start();
        logic [31:0] rd;
        axil_write(csr_pkg::w_flags, 32'h0000_000c);
        axil_write(csr_pkg::w_irq_test, 32'h0000_0001);
        axil_write(csr_pkg::w_ctrl, 32'h0000_0001);
        expect_pulse("soft_reset_pulse", 1);
        check_flags("flags after soft reset", flags, csr_pkg::flags_reset);
        axil_read(csr_pkg::w_int_status, rd);
        check_word("int_status after soft reset", rd, 32'h0000_0000);
        pulse_frame_done();
        axil_write(csr_pkg::w_irq_test, 32'h0000_0001);
        axil_write(csr_pkg::w_ctrl, 32'h0000_0002);
        expect_pulse("start_frame_pulse", 0);
        axil_read(csr_pkg::w_int_status, rd);
        check_word("int_status after start", rd, 32'h0000_0008);  // only bit 0 cleared
        axil_read(csr_pkg::w_status, rd);
        check_word("status after start", rd, 32'h0000_0000);
    endtask

    // ========================================
    // main sequence and watchdog
    // ========================================
    initial begin
        s_axil_awaddr    = '0;
        s_axil_awvalid   = 1'b0;
        s_axil_wdata     = '0;
        s_axil_wstrb     = '0;
        s_axil_wvalid    = 1'b0;
        s_axil_bready    = 1'b0;
        s_axil_araddr    = '0;
        s_axil_arvalid   = 1'b0;
        s_axil_rready    = 1'b0;
        frame_done_pulse = 1'b0;
        core_busy        = 1'b0;
        pulse_on         = '0;
        pulse_after      = '0;
        mismatches       = 0;
        failures         = 0;
        seed             = 32'h5c392e5f;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        reset_and_id();
        camera_regs();
        flag_regs();
        selection_regs();
        frame_done_irq();
        soft_reset_start();
        $display("errors: %0d mismatches, %0d handshake failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (num_tests * cycles_per_test) @(posedge clk);
        $display("ERROR: watchdog expired before the tests finished");
        $display("errors: %0d mismatches, %0d handshake failures", mismatches, failures);
        $display("Test failed");
        $finish;
    end

endmodule

// File: project.f
hdl/axil_pkg.sv
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/axil_slave_port.sv
hdl/render_ctrl_regs.sv
hdl/irq_status_regs.sv
hdl/voxel_csr_top.sv
verif/clk_gen.sv
verif/voxel_csr_tb.sv

// File: run.sh
#!/bin/sh
# build and run the voxel CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module voxel_csr_tb -o voxel_csr_sim
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/voxel_csr_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
